//--- common/vfu_pkg.sv
// Vector functional unit definitions
package vfu_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  // Datapath word
  localparam int unsigned WordWidth = 64;
  localparam int unsigned WordBytes = WordWidth / 8;

  // Register file layout
  localparam int unsigned NrVregs        = 32;
  localparam int unsigned NrWordsPerVreg = 4;

  // Result buffering and lane pipeline
  localparam int unsigned QueueDepth = 4;
  localparam int unsigned IpuLatency = 2;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [WordWidth-1:0] vword_t;
  typedef logic [WordBytes-1:0] vbe_t;

  // Register number times words per register plus word index
  typedef logic [$clog2(NrVregs*NrWordsPerVreg)-1:0] vreg_addr_t;
  typedef logic [$clog2(NrVregs)-1:0]                vreg_t;

  // Element count, up to one register of bytes
  typedef logic [$clog2(NrWordsPerVreg*WordBytes+1)-1:0] vlen_t;

  typedef logic [2:0]  vfu_id_t;
  typedef logic [31:0] rs_t;

  // Queue occupancy, 0 up to QueueDepth
  typedef logic [$clog2(QueueDepth+1)-1:0] qcnt_t;

  // Element width
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  // Integer operations
  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VMIN,
    VMAX,
    VMINU,
    VMAXU
  } vfu_op_e;

  // Issue FSM
  typedef enum logic {
    Idle,
    Running
  } issue_state_e;

endpackage : vfu_pkg

//--- rtl/vfu_ipu.sv
// SIMD integer lanes
`timescale 1ns/1ps

module vfu_ipu import vfu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Issued word
  input  logic       valid_i,
  input  vfu_op_e    op_i,
  input  vew_e       vsew_i,
  input  vword_t     a_i,
  input  vword_t     b_i,
  input  vreg_addr_t waddr_i,
  input  vfu_id_t    id_i,
  input  logic       last_i,
  input  logic       empty_i,
  // Result word
  output logic       valid_o,
  output vword_t     result_o,
  output vreg_addr_t waddr_o,
  output vfu_id_t    id_o,
  output logic       last_o,
  output logic       empty_o
);

  // Stage one
  logic       s1_valid_q;
  vfu_op_e    s1_op_q;
  vew_e       s1_vsew_q;
  vword_t     s1_a_q;
  vword_t     s1_b_q;
  vreg_addr_t s1_waddr_q;
  vfu_id_t    s1_id_q;
  logic       s1_last_q;
  logic       s1_empty_q;

  // Byte-sliced adder and per-byte compare flags
  vword_t arith;
  vbe_t   ltu;
  vbe_t   lts;
  vword_t alu_result;
  logic   [2:0] emask;

  assign emask = 3'((4'd1 << s1_vsew_q) - 4'd1);

  // Carry chain is cut at each element boundary
  always_comb begin : adder_proc
    logic [8:0] sum;
    logic       carry;
    logic       sub;
    sub   = s1_op_q inside {VSUB, VMIN, VMAX, VMINU, VMAXU};
    carry = 1'b0;
    for (int i = 0; i < WordBytes; i++) begin
      if ((3'(i) & emask) == 3'd0) begin
        carry = sub;
      end
      sum = {1'b0, s1_a_q[8*i +: 8]} + {1'b0, s1_b_q[8*i +: 8] ^ {8{sub}}} + 9'(carry);
      arith[8*i +: 8] = sum[7:0];
      carry           = sum[8];
      // Only meaningful at the top byte of an element
      ltu[i] = !carry;
      lts[i] = (s1_a_q[8*i+7] ^ s1_b_q[8*i+7]) ? s1_a_q[8*i+7] : !carry;
    end
  end

  always_comb begin : select_proc
    logic [2:0] top;
    logic       lt;
    for (int i = 0; i < WordBytes; i++) begin
      top = 3'(i) | emask;
      lt  = (s1_op_q inside {VMIN, VMAX}) ? lts[top] : ltu[top];
      unique case (s1_op_q)
        VADD, VSUB:   alu_result[8*i +: 8] = arith[8*i +: 8];
        VAND:         alu_result[8*i +: 8] = s1_a_q[8*i +: 8] & s1_b_q[8*i +: 8];
        VOR:          alu_result[8*i +: 8] = s1_a_q[8*i +: 8] | s1_b_q[8*i +: 8];
        VXOR:         alu_result[8*i +: 8] = s1_a_q[8*i +: 8] ^ s1_b_q[8*i +: 8];
        VMIN, VMINU:  alu_result[8*i +: 8] = lt ? s1_a_q[8*i +: 8] : s1_b_q[8*i +: 8];
        VMAX, VMAXU:  alu_result[8*i +: 8] = lt ? s1_b_q[8*i +: 8] : s1_a_q[8*i +: 8];
        default:      alu_result[8*i +: 8] = '0;
      endcase
    end
  end

  // Pipeline valids
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      valid_o    <= 1'b0;
    end else begin
      s1_valid_q <= valid_i;
      valid_o    <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      s1_op_q    <= op_i;
      s1_vsew_q  <= vsew_i;
      s1_a_q     <= a_i;
      s1_b_q     <= b_i;
      s1_waddr_q <= waddr_i;
      s1_id_q    <= id_i;
      s1_last_q  <= last_i;
      s1_empty_q <= empty_i;
    end
    if (s1_valid_q) begin
      result_o <= alu_result;
      waddr_o  <= s1_waddr_q;
      id_o     <= s1_id_q;
      last_o   <= s1_last_q;
      empty_o  <= s1_empty_q;
    end
  end

endmodule : vfu_ipu

//--- rtl/vfu_result_queue.sv
// Result word FIFO
`timescale 1ns/1ps

module vfu_result_queue import vfu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Write side, from the lanes
  input  logic       push_i,
  input  vword_t     data_i,
  input  vreg_addr_t waddr_i,
  input  vfu_id_t    id_i,
  input  logic       last_i,
  input  logic       empty_i,
  // Read side, to writeback
  input  logic       pop_i,
  output logic       valid_o,
  output vword_t     data_o,
  output vreg_addr_t waddr_o,
  output vfu_id_t    id_o,
  output logic       last_o,
  output logic       empty_o,
  output qcnt_t      free_o
);

  localparam int unsigned PtrWidth = $clog2(QueueDepth);

  vword_t     data_mem  [QueueDepth];
  vreg_addr_t waddr_mem [QueueDepth];
  vfu_id_t    id_mem    [QueueDepth];
  logic       last_mem  [QueueDepth];
  logic       empty_mem [QueueDepth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  qcnt_t               cnt_q;

  assign valid_o = cnt_q != '0;
  assign free_o  = qcnt_t'(QueueDepth) - cnt_q;

  assign data_o  = data_mem[rd_ptr_q];
  assign waddr_o = waddr_mem[rd_ptr_q];
  assign id_o    = id_mem[rd_ptr_q];
  assign last_o  = last_mem[rd_ptr_q];
  assign empty_o = empty_mem[rd_ptr_q];

  // Pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + qcnt_t'(push_i) - qcnt_t'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_mem[wr_ptr_q]  <= data_i;
      waddr_mem[wr_ptr_q] <= waddr_i;
      id_mem[wr_ptr_q]    <= id_i;
      last_mem[wr_ptr_q]  <= last_i;
      empty_mem[wr_ptr_q] <= empty_i;
    end
  end

endmodule : vfu_result_queue

//--- rtl/vfu_writeback.sv
// VRF writeback and completion
`timescale 1ns/1ps

module vfu_writeback import vfu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Queue head
  input  logic       q_valid_i,
  input  vword_t     q_data_i,
  input  vreg_addr_t q_waddr_i,
  input  vfu_id_t    q_id_i,
  input  logic       q_last_i,
  input  logic       q_empty_i,
  output logic       q_pop_o,
  // VRF write
  output vreg_addr_t vrf_waddr_o,
  output vword_t     vrf_wdata_o,
  output logic       vrf_we_o,
  output vbe_t       vrf_wbe_o,
  input  logic       vrf_wvalid_i,
  // Response
  output logic       rsp_valid_o,
  output vfu_id_t    rsp_id_o,
  input  logic       rsp_ready_i,
  // Retire pulse to issue
  output logic       done_o
);

  logic    rsp_q;
  vfu_id_t rsp_id_q;

  // Head is presented until the VRF acknowledges it
  assign vrf_waddr_o = q_waddr_i;
  assign vrf_wdata_o = q_data_i;
  assign vrf_wbe_o   = '1;
  assign vrf_we_o    = q_valid_i && !q_empty_i && !rsp_q;

  // Words of a zero-length instruction leave without a write
  assign q_pop_o = q_valid_i && !rsp_q && (q_empty_i || vrf_wvalid_i);

  assign rsp_valid_o = rsp_q;
  assign rsp_id_o    = rsp_id_q;
  assign done_o      = rsp_q && rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_q <= 1'b0;
    end else if (q_pop_o && q_last_i) begin
      rsp_q <= 1'b1;
    end else if (done_o) begin
      rsp_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (q_pop_o && q_last_i) begin
      rsp_id_q <= q_id_i;
    end
  end

endmodule : vfu_writeback

//--- rtl/vfu_issue/vfu_issue.sv
// Vector FU instruction issue
`timescale 1ns/1ps

module vfu_issue import vfu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  vfu_id_t              req_id_i,
  input  vfu_op_e              req_op_i,
  input  vew_e                 req_vsew_i,
  input  vlen_t                req_vl_i,
  input  vreg_t                req_vs1_i,
  input  vreg_t                req_vs2_i,
  input  vreg_t                req_vd_i,
  input  rs_t                  req_rs1_i,
  input  logic                 req_use_vs1_i,
  // VRF read, port 0 is vs2 and port 1 is vs1
  output vreg_addr_t [1:0]     vrf_raddr_o,
  output logic       [1:0]     vrf_re_o,
  input  vword_t     [1:0]     vrf_rdata_i,
  input  logic       [1:0]     vrf_rvalid_i,
  // Free result queue entries
  input  qcnt_t                q_free_i,
  // Lanes
  output logic                 issue_valid_o,
  output vfu_op_e              issue_op_o,
  output vew_e                 issue_vsew_o,
  output vword_t               operand_a_o,
  output vword_t               operand_b_o,
  output vreg_addr_t           issue_waddr_o,
  output vfu_id_t              issue_id_o,
  output logic                 issue_last_o,
  output logic                 issue_empty_o,
  // Instruction retired by writeback
  input  logic                 done_i
);

  issue_state_e state_q;
  // Instruction not yet retired
  logic         busy_q;

  // Latched instruction
  vfu_id_t id_q;
  vfu_op_e op_q;
  vew_e    vsew_q;
  vlen_t   vl_q;
  rs_t     rs1_q;
  logic    use_vs1_q;

  // Walking word addresses
  vreg_addr_t [1:0] raddr_q;
  vreg_addr_t       waddr_q;

  // Word bookkeeping
  vlen_t      elem_q;
  vlen_t      epw;
  logic [7:0] vl_bytes;
  logic [4:0] nr_words;
  logic [4:0] word_idx;
  logic       last_word;
  logic       empty_insn;

  // Words between issue and the queue write
  logic [IpuLatency-1:0] fire_pipe_q;
  qcnt_t                 inflight;

  logic   issue_ready;
  logic   operands_ready;
  logic   req_fire;
  logic   issue_fire;
  vword_t rs1_rep;

  //////////////////////////////////////////////////
  // Word count
  //////////////////////////////////////////////////

  assign epw        = vlen_t'(4'd8 >> vsew_q);
  assign vl_bytes   = 8'(vl_q) << vsew_q;
  assign nr_words   = 5'((vl_bytes + 8'd7) >> 3);
  assign word_idx   = 5'(elem_q >> (2'd3 - vsew_q));
  assign last_word  = (word_idx + 5'd1) >= nr_words;
  // vl of zero still sends one tagged word for the response
  assign empty_insn = nr_words == 5'd0;

  always_comb begin : inflight_proc
    inflight = '0;
    for (int i = 0; i < IpuLatency; i++) begin
      inflight = inflight + qcnt_t'(fire_pipe_q[i]);
    end
  end

  // Hold off once the queue could not take every word in the lanes
  assign issue_ready = q_free_i > inflight;

  // The VRF keeps rvalid high while the enable is held
  assign operands_ready = empty_insn ||
                          (vrf_rvalid_i[0] && (!use_vs1_q || vrf_rvalid_i[1]));

  assign req_ready_o = (state_q == Idle) && !busy_q;
  assign req_fire    = req_valid_i && req_ready_o;
  assign issue_fire  = (state_q == Running) && operands_ready && issue_ready;

  //////////////////////////////////////////////////
  // Operands
  //////////////////////////////////////////////////

  always_comb begin : rs1_rep_proc
    unique case (vsew_q)
      EW_8:    rs1_rep = {8{rs1_q[7:0]}};
      EW_16:   rs1_rep = {4{rs1_q[15:0]}};
      default: rs1_rep = {2{rs1_q}};
    endcase
  end

  assign vrf_raddr_o = raddr_q;
  assign vrf_re_o[0] = (state_q == Running) && !empty_insn;
  assign vrf_re_o[1] = (state_q == Running) && !empty_insn && use_vs1_q;

  assign issue_valid_o = issue_fire;
  assign issue_op_o    = op_q;
  assign issue_vsew_o  = vsew_q;
  assign operand_a_o   = vrf_rdata_i[0];
  assign operand_b_o   = use_vs1_q ? vrf_rdata_i[1] : rs1_rep;
  assign issue_waddr_o = waddr_q;
  assign issue_id_o    = id_q;
  assign issue_last_o  = last_word;
  assign issue_empty_o = empty_insn;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= Idle;
      busy_q      <= 1'b0;
      elem_q      <= '0;
      fire_pipe_q <= '0;
    end else begin
      fire_pipe_q <= {fire_pipe_q[IpuLatency-2:0], issue_fire};
      if (done_i) begin
        busy_q <= 1'b0;
      end
      unique case (state_q)
        Idle: begin
          if (req_fire) begin
            state_q <= Running;
            busy_q  <= 1'b1;
            elem_q  <= '0;
          end
        end
        Running: begin
          if (issue_fire) begin
            elem_q <= elem_q + epw;
            if (last_word) begin
              state_q <= Idle;
            end
          end
        end
      endcase
    end
  end

  // Instruction fields and addresses
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      id_q       <= req_id_i;
      op_q       <= req_op_i;
      vsew_q     <= req_vsew_i;
      vl_q       <= req_vl_i;
      rs1_q      <= req_rs1_i;
      use_vs1_q  <= req_use_vs1_i;
      raddr_q[0] <= vreg_addr_t'(req_vs2_i) << $clog2(NrWordsPerVreg);
      raddr_q[1] <= vreg_addr_t'(req_vs1_i) << $clog2(NrWordsPerVreg);
      waddr_q    <= vreg_addr_t'(req_vd_i) << $clog2(NrWordsPerVreg);
    end else if (issue_fire) begin
      raddr_q[0] <= raddr_q[0] + vreg_addr_t'(1);
      raddr_q[1] <= raddr_q[1] + vreg_addr_t'(1);
      waddr_q    <= waddr_q + vreg_addr_t'(1);
    end
  end

endmodule : vfu_issue

//--- rtl/vfu_top.sv
// Integer vector functional unit
`timescale 1ns/1ps

module vfu_top import vfu_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  // Request
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  vfu_id_t          req_id_i,
  input  vfu_op_e          req_op_i,
  input  vew_e             req_vsew_i,
  input  vlen_t            req_vl_i,
  input  vreg_t            req_vs1_i,
  input  vreg_t            req_vs2_i,
  input  vreg_t            req_vd_i,
  input  rs_t              req_rs1_i,
  input  logic             req_use_vs1_i,
  // VRF read
  output vreg_addr_t [1:0] vrf_raddr_o,
  output logic       [1:0] vrf_re_o,
  input  vword_t     [1:0] vrf_rdata_i,
  input  logic       [1:0] vrf_rvalid_i,
  // VRF write
  output vreg_addr_t       vrf_waddr_o,
  output vword_t           vrf_wdata_o,
  output logic             vrf_we_o,
  output vbe_t             vrf_wbe_o,
  input  logic             vrf_wvalid_i,
  // Response
  output logic             rsp_valid_o,
  output vfu_id_t          rsp_id_o,
  input  logic             rsp_ready_i
);

  // Issue to lanes
  logic       issue_valid;
  vfu_op_e    issue_op;
  vew_e       issue_vsew;
  vword_t     operand_a;
  vword_t     operand_b;
  vreg_addr_t issue_waddr;
  vfu_id_t    issue_id;
  logic       issue_last;
  logic       issue_empty;

  // Lanes to queue
  logic       ipu_valid;
  vword_t     ipu_result;
  vreg_addr_t ipu_waddr;
  vfu_id_t    ipu_id;
  logic       ipu_last;
  logic       ipu_empty;

  // Queue to writeback
  logic       q_valid;
  vword_t     q_data;
  vreg_addr_t q_waddr;
  vfu_id_t    q_id;
  logic       q_last;
  logic       q_empty;
  logic       q_pop;
  qcnt_t      q_free;

  logic done;

  vfu_issue i_issue (
    .clk_i         (clk_i        ),
    .rst_i         (rst_i        ),
    .req_valid_i   (req_valid_i  ),
    .req_ready_o   (req_ready_o  ),
    .req_id_i      (req_id_i     ),
    .req_op_i      (req_op_i     ),
    .req_vsew_i    (req_vsew_i   ),
    .req_vl_i      (req_vl_i     ),
    .req_vs1_i     (req_vs1_i    ),
    .req_vs2_i     (req_vs2_i    ),
    .req_vd_i      (req_vd_i     ),
    .req_rs1_i     (req_rs1_i    ),
    .req_use_vs1_i (req_use_vs1_i),
    .vrf_raddr_o   (vrf_raddr_o  ),
    .vrf_re_o      (vrf_re_o     ),
    .vrf_rdata_i   (vrf_rdata_i  ),
    .vrf_rvalid_i  (vrf_rvalid_i ),
    .q_free_i      (q_free       ),
    .issue_valid_o (issue_valid  ),
    .issue_op_o    (issue_op     ),
    .issue_vsew_o  (issue_vsew   ),
    .operand_a_o   (operand_a    ),
    .operand_b_o   (operand_b    ),
    .issue_waddr_o (issue_waddr  ),
    .issue_id_o    (issue_id     ),
    .issue_last_o  (issue_last   ),
    .issue_empty_o (issue_empty  ),
    .done_i        (done         )
  );

  vfu_ipu i_ipu (
    .clk_i    (clk_i      ),
    .rst_i    (rst_i      ),
    .valid_i  (issue_valid),
    .op_i     (issue_op   ),
    .vsew_i   (issue_vsew ),
    .a_i      (operand_a  ),
    .b_i      (operand_b  ),
    .waddr_i  (issue_waddr),
    .id_i     (issue_id   ),
    .last_i   (issue_last ),
    .empty_i  (issue_empty),
    .valid_o  (ipu_valid  ),
    .result_o (ipu_result ),
    .waddr_o  (ipu_waddr  ),
    .id_o     (ipu_id     ),
    .last_o   (ipu_last   ),
    .empty_o  (ipu_empty  )
  );

  vfu_result_queue i_result_queue (
    .clk_i   (clk_i     ),
    .rst_i   (rst_i     ),
    .push_i  (ipu_valid ),
    .data_i  (ipu_result),
    .waddr_i (ipu_waddr ),
    .id_i    (ipu_id    ),
    .last_i  (ipu_last  ),
    .empty_i (ipu_empty ),
    .pop_i   (q_pop     ),
    .valid_o (q_valid   ),
    .data_o  (q_data    ),
    .waddr_o (q_waddr   ),
    .id_o    (q_id      ),
    .last_o  (q_last    ),
    .empty_o (q_empty   ),
    .free_o  (q_free    )
  );

  vfu_writeback i_writeback (
    .clk_i        (clk_i       ),
    .rst_i        (rst_i       ),
    .q_valid_i    (q_valid     ),
    .q_data_i     (q_data      ),
    .q_waddr_i    (q_waddr     ),
    .q_id_i       (q_id        ),
    .q_last_i     (q_last      ),
    .q_empty_i    (q_empty     ),
    .q_pop_o      (q_pop       ),
    .vrf_waddr_o  (vrf_waddr_o ),
    .vrf_wdata_o  (vrf_wdata_o ),
    .vrf_we_o     (vrf_we_o    ),
    .vrf_wbe_o    (vrf_wbe_o   ),
    .vrf_wvalid_i (vrf_wvalid_i),
    .rsp_valid_o  (rsp_valid_o ),
    .rsp_id_o     (rsp_id_o    ),
    .rsp_ready_i  (rsp_ready_i ),
    .done_o       (done        )
  );

endmodule : vfu_top

//--- tb/vfu_tb.sv
// Vector FU testbench
`timescale 1ns/1ps

module vfu_tb import vfu_pkg::*; ();

  localparam int          ClkPeriod   = 100;
  localparam int          DriveDelay  = 10;
  localparam int          ResetCycles = 5;
  localparam int          NrTests     = 87;
  localparam int          MaxWords    = NrWordsPerVreg;
  localparam int          LongStall   = 40;
  localparam int          VrfWords    = NrVregs * NrWordsPerVreg;
  localparam logic [31:0] Seed        = 32'h3706e8d6;

  logic             clk;
  logic             rst;
  logic             req_valid;
  logic             req_ready;
  vfu_id_t          req_id;
  vfu_op_e          req_op;
  vew_e             req_vsew;
  vlen_t            req_vl;
  vreg_t            req_vs1;
  vreg_t            req_vs2;
  vreg_t            req_vd;
  rs_t              req_rs1;
  logic             req_use_vs1;
  vreg_addr_t [1:0] vrf_raddr;
  logic       [1:0] vrf_re;
  vword_t     [1:0] vrf_rdata;
  logic       [1:0] vrf_rvalid;
  vreg_addr_t       vrf_waddr;
  vword_t           vrf_wdata;
  logic             vrf_we;
  vbe_t             vrf_wbe;
  logic             vrf_wvalid;
  logic             rsp_valid;
  vfu_id_t          rsp_id;
  logic             rsp_ready;

  // VRF contents and the expected copy
  vword_t vrf_mem [VrfWords];
  vword_t ref_mem [VrfWords];

  int      errors;
  int      tests_run;
  int      tests_failed;
  int      wr_count;
  int      rsp_count;
  int      rsp_wr_count;
  int      long_stall;
  int      cur_base;
  int      cur_nw;
  logic    rsp_expected;
  vfu_id_t last_rsp_id;

  // Read port state
  logic [1:0] rd_active;
  vreg_addr_t rd_addr [2];
  int         rd_wait [2];

  vfu_top dut (
    .clk_i         (clk        ),
    .rst_i         (rst        ),
    .req_valid_i   (req_valid  ),
    .req_ready_o   (req_ready  ),
    .req_id_i      (req_id     ),
    .req_op_i      (req_op     ),
    .req_vsew_i    (req_vsew   ),
    .req_vl_i      (req_vl     ),
    .req_vs1_i     (req_vs1    ),
    .req_vs2_i     (req_vs2    ),
    .req_vd_i      (req_vd     ),
    .req_rs1_i     (req_rs1    ),
    .req_use_vs1_i (req_use_vs1),
    .vrf_raddr_o   (vrf_raddr  ),
    .vrf_re_o      (vrf_re     ),
    .vrf_rdata_i   (vrf_rdata  ),
    .vrf_rvalid_i  (vrf_rvalid ),
    .vrf_waddr_o   (vrf_waddr  ),
    .vrf_wdata_o   (vrf_wdata  ),
    .vrf_we_o      (vrf_we     ),
    .vrf_wbe_o     (vrf_wbe    ),
    .vrf_wvalid_i  (vrf_wvalid ),
    .rsp_valid_o   (rsp_valid  ),
    .rsp_id_o      (rsp_id     ),
    .rsp_ready_i   (rsp_ready  )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Longest allowed run with every test at full length
  initial begin
    repeat (NrTests * MaxWords * 40 + ResetCycles + 10) @(posedge clk);
    $display("Watchdog expired before all tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Per element result with operand a from vs2 and operand b from vs1 or rs1
  function automatic vword_t expected_word(vfu_op_e op, vew_e ew, vword_t a, vword_t b);
    int              bits;
    longint unsigned mask;
    longint unsigned ea;
    longint unsigned eb;
    longint unsigned r;
    longint          sa;
    longint          sb;
    vword_t          res;
    bits = 8 << ew;
    mask = (64'd1 << bits) - 64'd1;
    res  = '0;
    for (int e = 0; e < WordWidth / bits; e++) begin
      ea = (a >> (e * bits)) & mask;
      eb = (b >> (e * bits)) & mask;
      sa = longint'(ea);
      sb = longint'(eb);
      if ((ea >> (bits - 1)) != 0) sa = sa - (longint'(1) << bits);
      if ((eb >> (bits - 1)) != 0) sb = sb - (longint'(1) << bits);
      case (op)
        VADD:    r = ea + eb;
        VSUB:    r = ea - eb;
        VAND:    r = ea & eb;
        VOR:     r = ea | eb;
        VXOR:    r = ea ^ eb;
        VMIN:    r = (sa < sb) ? ea : eb;
        VMAX:    r = (sa > sb) ? ea : eb;
        VMINU:   r = (ea < eb) ? ea : eb;
        VMAXU:   r = (ea > eb) ? ea : eb;
        default: r = 0;
      endcase
      res = res | vword_t'((r & mask) << (e * bits));
    end
    return res;
  endfunction

  // Scalar truncated to the element width in every element
  function automatic vword_t splat_scalar(rs_t rs1, vew_e ew);
    int     bits;
    vword_t res;
    bits = 8 << ew;
    res  = '0;
    for (int e = 0; e < WordWidth / bits; e++) begin
      res = res | (((vword_t'(rs1) << (64 - bits)) >> (64 - bits)) << (e * bits));
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected=%h actual=%h", name, expected, actual);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // VRF model
  //////////////////////////////////////////////////

  // Rvalid stays high with the data until the address moves on
  task automatic serve_read(input int p);
    if (!vrf_re[p]) begin
      rd_active[p]  = 1'b0;
      vrf_rvalid[p] = 1'b0;
      vrf_rdata[p]  = '0;
    end else begin
      if (!rd_active[p] || rd_addr[p] != vrf_raddr[p]) begin
        rd_active[p] = 1'b1;
        rd_addr[p]   = vrf_raddr[p];
        rd_wait[p]   = $urandom % 4;
      end
      if (rd_wait[p] == 0) begin
        vrf_rvalid[p] = 1'b1;
        vrf_rdata[p]  = vrf_mem[rd_addr[p]];
      end else begin
        rd_wait[p]--;
        vrf_rvalid[p] = 1'b0;
        vrf_rdata[p]  = '0;
      end
    end
  endtask

  initial begin
    vrf_rdata  = '0;
    vrf_rvalid = '0;
    vrf_wvalid = 1'b0;
    rsp_ready  = 1'b0;
    rd_active  = '0;
    long_stall = 0;
    forever begin
      @(posedge clk);
      #DriveDelay;
      serve_read(0);
      serve_read(1);
      if (long_stall > 0) begin
        long_stall--;
        vrf_wvalid = 1'b0;
      end else begin
        vrf_wvalid = ($urandom % 4) != 0;
      end
      rsp_ready = ($urandom % 3) != 0;
    end
  end

  // Write and response monitor
  initial begin
    forever begin
      @(negedge clk);
      if (!rst && vrf_we && vrf_wvalid) begin
        if (int'(vrf_waddr) < cur_base || int'(vrf_waddr) >= cur_base + cur_nw) begin
          $display("Write to word %0d lies outside the destination words", vrf_waddr);
          errors++;
        end
        if (vrf_wbe !== '1) begin
          $display("Write to word %0d does not have every byte enabled", vrf_waddr);
          errors++;
        end
        vrf_mem[vrf_waddr] = vrf_wdata;
        wr_count++;
      end
      if (!rst && rsp_valid && rsp_ready) begin
        if (!rsp_expected) begin
          $display("Response with id %0d arrived with no instruction outstanding", rsp_id);
          errors++;
        end
        rsp_expected = 1'b0;
        last_rsp_id  = rsp_id;
        rsp_wr_count = wr_count;
        rsp_count++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic run_test(input vfu_op_e op, input vew_e ew, input int vl,
                          input logic use_vs1, input bit stall);
    string   name;
    vreg_t   vs1;
    vreg_t   vs2;
    vreg_t   vd;
    rs_t     rs1;
    vfu_id_t id;
    int      nw;
    int      err_before;
    int      rsp_before;
    vword_t  a;
    vword_t  b;
    vs1        = vreg_t'($urandom);
    vs2        = vreg_t'($urandom);
    vd         = vreg_t'($urandom);
    rs1        = $urandom;
    id         = vfu_id_t'(tests_run);
    name       = $sformatf("t%0d_%s_e%0d", tests_run, op.name(), 8 << ew);
    nw         = (vl * (1 << ew) + 7) / 8;
    err_before = errors;
    rsp_before = rsp_count;

    for (int w = 0; w < nw; w++) begin
      a = ref_mem[int'(vs2) * NrWordsPerVreg + w];
      b = use_vs1 ? ref_mem[int'(vs1) * NrWordsPerVreg + w] : splat_scalar(rs1, ew);
      ref_mem[int'(vd) * NrWordsPerVreg + w] = expected_word(op, ew, a, b);
    end

    @(posedge clk);
    #DriveDelay;
    cur_base     = int'(vd) * NrWordsPerVreg;
    cur_nw       = nw;
    wr_count     = 0;
    rsp_expected = 1'b1;
    req_id       = id;
    req_op       = op;
    req_vsew     = ew;
    req_vl       = vlen_t'(vl);
    req_vs1      = vs1;
    req_vs2      = vs2;
    req_vd       = vd;
    req_rs1      = rs1;
    req_use_vs1  = use_vs1;
    req_valid    = 1'b1;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    // Hold the writes long enough for the queue to fill
    if (stall) long_stall = LongStall;
    @(posedge clk);
    #DriveDelay;
    req_valid = 1'b0;

    wait (rsp_count != rsp_before);
    check_value({name, "_rsp_id"}, id, last_rsp_id);
    check_value({name, "_writes"}, nw, rsp_wr_count);
    for (int i = 0; i < VrfWords; i++) begin
      check_value($sformatf("%s_word%0d", name, i), ref_mem[i], vrf_mem[i]);
    end

    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("%-22s vl=%2d %s %s", name, vl, use_vs1 ? "vv" : "vx",
             (errors == err_before) ? "ok" : "failed");
  endtask

  initial begin : main_proc
    int     max_vl;
    vew_e   ew;
    vfu_op_e op;
    bit     stall;

    req_valid    = 1'b0;
    req_id       = '0;
    req_op       = VADD;
    req_vsew     = EW_8;
    req_vl       = '0;
    req_vs1      = '0;
    req_vs2      = '0;
    req_vd       = '0;
    req_rs1      = '0;
    req_use_vs1  = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    wr_count     = 0;
    rsp_count    = 0;
    rsp_wr_count = 0;
    cur_base     = 0;
    cur_nw       = 0;
    rsp_expected = 1'b0;
    rst          = 1'b1;

    void'($urandom(Seed));
    for (int i = 0; i < VrfWords; i++) begin
      vrf_mem[i] = {$urandom, $urandom};
      ref_mem[i] = vrf_mem[i];
    end

    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst = 1'b0;
    @(negedge clk);
    check_value("reset_req_ready", 1, req_ready);
    check_value("reset_vrf_re", 0, vrf_re);
    check_value("reset_vrf_we", 0, vrf_we);
    check_value("reset_rsp_valid", 0, rsp_valid);

    // Every operation at every width over a full register of vector operands
    for (int o = 0; o < 9; o++) begin
      for (int e = 0; e < 3; e++) begin
        run_test(vfu_op_e'(o), vew_e'(e), 32 >> e, 1'b1, 1'b0);
      end
    end

    // Scalar operand at random lengths
    for (int o = 0; o < 9; o++) begin
      for (int e = 0; e < 3; e++) begin
        run_test(vfu_op_e'(o), vew_e'(e), 1 + $urandom % (32 >> e), 1'b0, 1'b0);
      end
    end

    // Zero length
    for (int e = 0; e < 3; e++) begin
      run_test(VADD, vew_e'(e), 0, e[0], 1'b0);
    end

    // Random mix with a long write stall every sixth test
    for (int k = 0; k < 30; k++) begin
      op     = vfu_op_e'($urandom % 9);
      ew     = vew_e'($urandom % 3);
      max_vl = 32 >> ew;
      stall  = (k % 6) == 0;
      run_test(op, ew, stall ? max_vl : $urandom % (max_vl + 1), $urandom % 2, stall);
    end

    repeat (4) @(posedge clk);
    check_value("response_total", NrTests, rsp_count);

    $display("tests=%0d passed=%0d failed=%0d errors=%0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_run == NrTests) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : vfu_tb

//--- sources.f
common/vfu_pkg.sv
rtl/vfu_ipu.sv
rtl/vfu_result_queue.sv
rtl/vfu_writeback.sv
rtl/vfu_issue/vfu_issue.sv
rtl/vfu_top.sv
tb/vfu_tb.sv

//--- Bender.yml
package:
  name: vfu

sources:
  - files:
      - common/vfu_pkg.sv
      - rtl/vfu_ipu.sv
      - rtl/vfu_result_queue.sv
      - rtl/vfu_writeback.sv
      - rtl/vfu_issue/vfu_issue.sv
      - rtl/vfu_top.sv
  - target: simulation
    files:
      - tb/vfu_tb.sv
